/* verilog/ccl_pkg.sv */
// connected-component labeler shared sizes, widths and enum types
package ccl_pkg;

    // frame geometry
    localparam int IMG_W = 16;
    localparam int IMG_H = 8;
    localparam int X_W   = 4;
    localparam int Y_W   = 3;

    // label 0 is background
    localparam int LABEL_W    = 7;
    localparam int MAX_LABELS = 128;

    // full frame of 128 pixels fits
    localparam int AREA_W = 8;

    // one frame needs at most 129 entries
    localparam int FIFO_DEPTH = 256;
    localparam int FIFO_AW    = 8;

    // request opcodes from the first pass
    typedef enum logic [1:0] {
        OP_NEW  = 2'd0,
        OP_MARK = 2'd1,
        OP_JOIN = 2'd2,
        OP_END  = 2'd3
    } ccl_op_e;

    // resolver FSM
    typedef enum logic [2:0] {
        RS_IDLE = 3'd0,
        RS_FIND = 3'd1,
        RS_FOLD = 3'd2,
        RS_EMIT = 3'd3,
        RS_DONE = 3'd4
    } res_state_e;

endpackage

/* verilog/ccl_req_if.sv */
// labeling request links, push side into the queue and pop side out of it
`timescale 1ns/10ps

interface ccl_req_if
    import ccl_pkg::*;
();
    logic               valid;
    ccl_op_e            op;
    logic [LABEL_W-1:0] label_a;
    logic [LABEL_W-1:0] label_b;

    modport producer (output valid, output op, output label_a, output label_b);
    modport queue    (input valid, input op, input label_a, input label_b);
endinterface

interface ccl_pop_if
    import ccl_pkg::*;
();
    logic               pop;
    logic               empty;
    ccl_op_e            op;
    logic [LABEL_W-1:0] label_a;
    logic [LABEL_W-1:0] label_b;

    // head entry is valid while empty is low
    modport queue    (input pop, output empty, output op, output label_a, output label_b);
    modport consumer (output pop, input empty, input op, input label_a, input label_b);
endinterface

/* verilog/ccl_first_pass.sv */
// first pass raster scan, provisional labels and equivalence requests
`timescale 1ns/10ps

module ccl_first_pass
    import ccl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_fifo,
    input  logic        pix_valid_i,
    input  logic        pix_i,
    ccl_req_if.producer req
);

    logic [X_W-1:0]     x_q;
    logic [Y_W-1:0]     y_q;
    logic [LABEL_W-1:0] left_q;
    logic [LABEL_W-1:0] label_cnt_q;
    logic               end_pend_q;

    // labels of the previous row, indexed by column
    logic [LABEL_W-1:0] row_buf [IMG_W];

    logic [LABEL_W-1:0] left_lbl;
    logic [LABEL_W-1:0] above_lbl;
    logic [LABEL_W-1:0] cur_lbl;
    logic [LABEL_W-1:0] max_lbl;
    ccl_op_e            cur_op;
    logic               last_pix;

    assign last_pix  = (x_q == X_W'(IMG_W - 1)) && (y_q == Y_W'(IMG_H - 1));

    // no neighbours outside the frame
    assign left_lbl  = (x_q == '0) ? '0 : left_q;
    assign above_lbl = (y_q == '0) ? '0 : row_buf[x_q];

    // label choice, 4-connectivity
    always_comb begin
        cur_op  = OP_MARK;
        cur_lbl = '0;
        max_lbl = '0;
        if (!pix_i) begin
            cur_lbl = '0;
        end else if (left_lbl == '0 && above_lbl == '0) begin
            cur_op  = OP_NEW;
            cur_lbl = label_cnt_q + LABEL_W'(1);
        end else if (left_lbl == '0) begin
            cur_lbl = above_lbl;
        end else if (above_lbl == '0 || above_lbl == left_lbl) begin
            cur_lbl = left_lbl;
        end else begin
            // two different labels meet, keep the smaller one
            cur_op = OP_JOIN;
            if (left_lbl < above_lbl) begin
                cur_lbl = left_lbl;
                max_lbl = above_lbl;
            end else begin
                cur_lbl = above_lbl;
                max_lbl = left_lbl;
            end
        end
    end

    // scan position, label counter and request strobe
    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            x_q         <= '0;
            y_q         <= '0;
            label_cnt_q <= '0;
            end_pend_q  <= 1'b0;
            req.valid   <= 1'b0;
        end else begin
            req.valid  <= end_pend_q;
            end_pend_q <= 1'b0;
            if (pix_valid_i) begin
                if (pix_i) begin
                    req.valid <= 1'b1;
                end
                if (last_pix) begin
                    x_q         <= '0;
                    y_q         <= '0;
                    label_cnt_q <= '0;
                    // a foreground last pixel takes the slot, end marker follows
                    if (pix_i) begin
                        end_pend_q <= 1'b1;
                    end else begin
                        req.valid <= 1'b1;
                    end
                end else begin
                    if (x_q == X_W'(IMG_W - 1)) begin
                        x_q <= '0;
                        y_q <= y_q + Y_W'(1);
                    end else begin
                        x_q <= x_q + X_W'(1);
                    end
                    if (pix_i && cur_op == OP_NEW) begin
                        label_cnt_q <= cur_lbl;
                    end
                end
            end
        end
    end

    // request payload and label history
    always_ff @(posedge clk) begin
        if (end_pend_q || (pix_valid_i && last_pix && !pix_i)) begin
            req.op      <= OP_END;
            req.label_a <= '0;
            req.label_b <= '0;
        end else if (pix_valid_i && pix_i) begin
            req.op      <= cur_op;
            req.label_a <= cur_lbl;
            req.label_b <= max_lbl;
        end
        if (pix_valid_i) begin
            row_buf[x_q] <= cur_lbl;
            left_q       <= cur_lbl;
        end
    end

endmodule

/* verilog/ccl_req_fifo.sv */
// request queue between first pass and resolver, one frame deep
`timescale 1ns/10ps

module ccl_req_fifo
    import ccl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_fifo,
    ccl_req_if.queue push,
    ccl_pop_if.queue pop
);

    ccl_op_e            op_mem [FIFO_DEPTH];
    logic [LABEL_W-1:0] a_mem  [FIFO_DEPTH];
    logic [LABEL_W-1:0] b_mem  [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q;
    logic               do_pop;

    assign do_pop = pop.pop && !pop.empty;

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push.valid) begin
                wr_ptr_q <= wr_ptr_q + FIFO_AW'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + FIFO_AW'(1);
            end
            case ({push.valid, do_pop})
                2'b10:   count_q <= count_q + (FIFO_AW + 1)'(1);
                2'b01:   count_q <= count_q - (FIFO_AW + 1)'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push.valid) begin
            op_mem[wr_ptr_q] <= push.op;
            a_mem[wr_ptr_q]  <= push.label_a;
            b_mem[wr_ptr_q]  <= push.label_b;
        end
    end

    // head entry straight from the array
    assign pop.empty   = (count_q == '0);
    assign pop.op      = op_mem[rd_ptr_q];
    assign pop.label_a = a_mem[rd_ptr_q];
    assign pop.label_b = b_mem[rd_ptr_q];

endmodule

/* verilog/ccl_resolver.sv */
// union-find resolver, area counting and end-of-frame component report
`timescale 1ns/10ps

module ccl_resolver
    import ccl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_fifo,
    ccl_pop_if.consumer        pop,
    output logic               result_valid_o,
    output logic [LABEL_W-1:0] result_label_o,
    output logic [AREA_W-1:0]  result_area_o,
    output logic               frame_done_o
);

    res_state_e         state_q;

    // equivalence and area tables, indexed by label
    logic [LABEL_W-1:0] parent_q [MAX_LABELS];
    logic [AREA_W-1:0]  area_q   [MAX_LABELS];

    logic [LABEL_W-1:0] label_cnt_q;
    logic [LABEL_W-1:0] root_a_q;
    logic [LABEL_W-1:0] root_b_q;
    // scan index and the walk pointer of its find chain
    logic [LABEL_W-1:0] idx_q;
    logic [LABEL_W-1:0] walk_q;

    logic               a_is_root;
    logic               b_is_root;
    logic               walk_is_root;

    assign a_is_root    = (parent_q[root_a_q] == root_a_q);
    assign b_is_root    = (parent_q[root_b_q] == root_b_q);
    assign walk_is_root = (parent_q[walk_q] == walk_q);

    // only take requests while nothing else is in progress
    assign pop.pop = (state_q == RS_IDLE) && !pop.empty;

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            state_q        <= RS_IDLE;
            label_cnt_q    <= '0;
            result_valid_o <= 1'b0;
            frame_done_o   <= 1'b0;
            for (int i = 0; i < MAX_LABELS; i++) begin
                parent_q[i] <= '0;
                area_q[i]   <= '0;
            end
        end else begin
            result_valid_o <= 1'b0;
            frame_done_o   <= 1'b0;
            case (state_q)
                RS_IDLE: begin
                    if (pop.pop) begin
                        case (pop.op)
                            OP_NEW: begin
                                parent_q[pop.label_a] <= pop.label_a;
                                area_q[pop.label_a]   <= area_q[pop.label_a] + AREA_W'(1);
                                label_cnt_q           <= label_cnt_q + LABEL_W'(1);
                            end
                            OP_MARK: begin
                                area_q[pop.label_a] <= area_q[pop.label_a] + AREA_W'(1);
                            end
                            OP_JOIN: begin
                                area_q[pop.label_a] <= area_q[pop.label_a] + AREA_W'(1);
                                root_a_q            <= pop.label_a;
                                root_b_q            <= pop.label_b;
                                state_q             <= RS_FIND;
                            end
                            default: begin
                                // end of frame, empty frames finish at once
                                if (label_cnt_q == '0) begin
                                    frame_done_o <= 1'b1;
                                end else begin
                                    idx_q   <= LABEL_W'(1);
                                    walk_q  <= LABEL_W'(1);
                                    state_q <= RS_FOLD;
                                end
                            end
                        endcase
                    end
                end

                RS_FIND: begin
                    // one step up both chains per cycle
                    if (a_is_root && b_is_root) begin
                        if (root_a_q < root_b_q) begin
                            parent_q[root_b_q] <= root_a_q;
                        end else if (root_b_q < root_a_q) begin
                            parent_q[root_a_q] <= root_b_q;
                        end
                        state_q <= RS_IDLE;
                    end else begin
                        if (!a_is_root) begin
                            root_a_q <= parent_q[root_a_q];
                        end
                        if (!b_is_root) begin
                            root_b_q <= parent_q[root_b_q];
                        end
                    end
                end

                RS_FOLD: begin
                    if (!walk_is_root) begin
                        walk_q <= parent_q[walk_q];
                    end else begin
                        // non-roots never receive area, so their own count is intact
                        if (walk_q != idx_q) begin
                            area_q[walk_q] <= area_q[walk_q] + area_q[idx_q];
                        end
                        // shortcut later walks through this label
                        parent_q[idx_q] <= walk_q;
                        if (idx_q == label_cnt_q) begin
                            idx_q   <= LABEL_W'(1);
                            state_q <= RS_EMIT;
                        end else begin
                            idx_q  <= idx_q + LABEL_W'(1);
                            walk_q <= idx_q + LABEL_W'(1);
                        end
                    end
                end

                RS_EMIT: begin
                    if (parent_q[idx_q] == idx_q) begin
                        result_valid_o <= 1'b1;
                        result_label_o <= idx_q;
                        result_area_o  <= area_q[idx_q];
                    end
                    // tables are left clean for the next frame
                    parent_q[idx_q] <= '0;
                    area_q[idx_q]   <= '0;
                    if (idx_q == label_cnt_q) begin
                        state_q <= RS_DONE;
                    end else begin
                        idx_q <= idx_q + LABEL_W'(1);
                    end
                end

                RS_DONE: begin
                    frame_done_o <= 1'b1;
                    label_cnt_q  <= '0;
                    state_q      <= RS_IDLE;
                end

                default: begin
                    state_q <= RS_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/ccl_top.sv */
// connected-component labeler top, first pass into queue into resolver
`timescale 1ns/10ps

module ccl_top
    import ccl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_fifo,
    input  logic               pix_valid_i,
    input  logic               pix_i,
    output logic               result_valid_o,
    output logic [LABEL_W-1:0] result_label_o,
    output logic [AREA_W-1:0]  result_area_o,
    output logic               frame_done_o
);

    ccl_req_if u_req_if ();
    ccl_pop_if u_pop_if ();

    ccl_first_pass u_first_pass (
        .clk         (clk),
        .rst_fifo    (rst_fifo),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .req         (u_req_if.producer)
    );

    ccl_req_fifo u_req_fifo (
        .clk      (clk),
        .rst_fifo (rst_fifo),
        .push     (u_req_if.queue),
        .pop      (u_pop_if.queue)
    );

    ccl_resolver u_resolver (
        .clk            (clk),
        .rst_fifo       (rst_fifo),
        .pop            (u_pop_if.consumer),
        .result_valid_o (result_valid_o),
        .result_label_o (result_label_o),
        .result_area_o  (result_area_o),
        .frame_done_o   (frame_done_o)
    );

endmodule

/* dv/ccl_checker.sv */
// result monitor, compares reported components with the golden lists
`timescale 1ns/10ps

module ccl_checker
    import ccl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_fifo,
    input  logic               result_valid_i,
    input  logic [LABEL_W-1:0] result_label_i,
    input  logic [AREA_W-1:0]  result_area_i,
    input  logic               frame_done_i,
    output int                 tests_passed_o,
    output int                 tests_failed_o
);

    // flat pair lists, each test owns a slice
    int    exp_label [$];
    int    exp_area  [$];
    int    exp_first [$];
    int    exp_num   [$];
    string names     [$];
    int    test_idx;
    int    res_idx;
    bit    test_bad;

    function automatic void read_expected();
        int               fd;
        int               lbl;
        int               area;
        string            tok;
        string            line;
        logic [IMG_W-1:0] row;
        fd = $fopen("dv/ccl_golden.txt", "r");
        while (fd != 0 && $fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(line, fd));
            end else if (tok == "test") begin
                void'($fscanf(fd, "%s", tok));
                names.push_back(tok);
                exp_first.push_back(exp_label.size());
                for (int y = 0; y < IMG_H; y++) begin
                    void'($fscanf(fd, "%b", row));
                end
                // label area pairs up to the end token
                while ($fscanf(fd, "%s", tok) == 1 && tok != "end") begin
                    void'($sscanf(tok, "%d", lbl));
                    void'($fscanf(fd, "%d", area));
                    exp_label.push_back(lbl);
                    exp_area.push_back(area);
                end
                exp_num.push_back(exp_label.size() - exp_first[$]);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endfunction

    task automatic check_result();
        int k;
        if (test_idx >= exp_num.size() || res_idx >= exp_num[test_idx]) begin
            $display("test %0d reported an extra component, label %0d area %0d",
                     test_idx, result_label_i, result_area_i);
            test_bad = 1'b1;
        end else begin
            k = exp_first[test_idx] + res_idx;
            if (result_label_i != exp_label[k] || result_area_i != exp_area[k]) begin
                $display("ERROR %0t: test %0d result %0d is label %0d area %0d, expected %0d %0d",
                         $time, test_idx, res_idx, result_label_i, result_area_i,
                         exp_label[k], exp_area[k]);
                test_bad = 1'b1;
            end
        end
        res_idx++;
    endtask

    task automatic close_test();
        if (test_idx >= exp_num.size()) begin
            $display("frame %0d finished but the golden file has no such test", test_idx);
            test_bad = 1'b1;
        end else if (res_idx < exp_num[test_idx]) begin
            $display("test %0d is missing components, got %0d of %0d",
                     test_idx, res_idx, exp_num[test_idx]);
            test_bad = 1'b1;
        end
        if (test_bad) begin
            tests_failed_o++;
        end else begin
            tests_passed_o++;
        end
        $display("test %0d %s: %s with %0d components", test_idx,
                 (test_idx < names.size()) ? names[test_idx] : "unknown",
                 test_bad ? "fail" : "pass", res_idx);
        test_idx++;
        res_idx  = 0;
        test_bad = 1'b0;
    endtask

    initial begin
        read_expected();
    end

    always @(posedge clk) begin
        if (rst_fifo) begin
            test_idx       = 0;
            res_idx        = 0;
            test_bad       = 1'b0;
            tests_passed_o = 0;
            tests_failed_o = 0;
        end else begin
            if (result_valid_i) begin
                check_result();
            end
            if (frame_done_i) begin
                close_test();
            end
        end
    end

endmodule

/* dv/ccl_tb.sv */
// testbench for the connected-component labeler, frames from the golden file
`timescale 1ns/10ps

module ccl_tb
    import ccl_pkg::*;
();

    // pixels at up to 4 cycles each plus resolver time
    localparam int FRAME_CYCLES = IMG_W * IMG_H * 4 + 8000;

    logic               clk;
    logic               rst_fifo;
    logic               pix_valid_i;
    logic               pix_i;
    logic               result_valid_o;
    logic [LABEL_W-1:0] result_label_o;
    logic [AREA_W-1:0]  result_area_o;
    logic               frame_done_o;
    int                 tests_passed;
    int                 tests_failed;

    // frame rows, IMG_H per test, column 0 in the msb
    logic [IMG_W-1:0]   rows [$];
    string              names [$];
    int                 cur_frame;
    logic               loaded;

    ccl_top u_dut (
        .clk            (clk),
        .rst_fifo       (rst_fifo),
        .pix_valid_i    (pix_valid_i),
        .pix_i          (pix_i),
        .result_valid_o (result_valid_o),
        .result_label_o (result_label_o),
        .result_area_o  (result_area_o),
        .frame_done_o   (frame_done_o)
    );

    ccl_checker u_checker (
        .clk            (clk),
        .rst_fifo       (rst_fifo),
        .result_valid_i (result_valid_o),
        .result_label_i (result_label_o),
        .result_area_i  (result_area_o),
        .frame_done_i   (frame_done_o),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // picks the pixel rows out of the golden file, pairs are skipped
    function automatic int read_frames();
        int               fd;
        string            tok;
        string            line;
        logic [IMG_W-1:0] row;
        fd = $fopen("dv/ccl_golden.txt", "r");
        if (fd == 0) begin
            return 0;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(line, fd));
            end else if (tok == "test") begin
                void'($fscanf(fd, "%s", tok));
                names.push_back(tok);
                for (int y = 0; y < IMG_H; y++) begin
                    void'($fscanf(fd, "%b", row));
                    rows.push_back(row);
                end
            end
        end
        $fclose(fd);
        return names.size();
    endfunction

    // raster order, 0 to 3 idle cycles before each pixel
    task automatic send_frame(input int f);
        int               gap;
        logic [IMG_W-1:0] row;
        for (int y = 0; y < IMG_H; y++) begin
            row = rows[f * IMG_H + y];
            for (int x = 0; x < IMG_W; x++) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(posedge clk);
                    pix_valid_i <= 1'b0;
                end
                @(posedge clk);
                pix_valid_i <= 1'b1;
                pix_i       <= row[IMG_W - 1 - x];
            end
        end
        @(posedge clk);
        pix_valid_i <= 1'b0;
    endtask

    task automatic wait_frame_done();
        do begin
            @(posedge clk);
        end while (frame_done_o !== 1'b1);
    endtask

    initial begin
        void'($urandom(54));
        rst_fifo    = 1'b1;
        pix_valid_i = 1'b0;
        pix_i       = 1'b0;
        cur_frame   = 0;
        loaded      = 1'b0;
        if (read_frames() == 0) begin
            $display("no frames could be read from dv/ccl_golden.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (16) @(posedge clk);
            rst_fifo <= 1'b0;
            for (cur_frame = 0; cur_frame < names.size(); cur_frame++) begin
                send_frame(cur_frame);
                wait_frame_done();
            end
            repeat (4) @(posedge clk);
            $display("summary: %0d tests passed, %0d failed", tests_passed, tests_failed);
            if (tests_failed == 0 && tests_passed == names.size()) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // watchdog, bound scales with the number of frames
    initial begin
        wait (loaded);
        repeat (names.size() * FRAME_CYCLES + 16) @(posedge clk);
        $display("timeout: frame %0d (%s) never finished", cur_frame, names[cur_frame]);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* dv/ccl_golden.txt */
# test <name>, then 8 rows of 16 pixels with column 0 on the left,
# then expected components as label area pairs in label order, closed by end
test blob
0000000000000000
0000111100000000
0001111110000000
0001111110000000
0000111100000000
0000000000000000
0000000000000000
0000000000000000
1 20 end
test checkerboard
1010101010101010
0101010101010101
1010101010101010
0101010101010101
1010101010101010
0101010101010101
1010101010101010
0101010101010101
1 1 2 1 3 1 4 1 5 1 6 1 7 1 8 1 9 1 10 1 11 1 12 1 13 1 14 1 15 1 16 1
17 1 18 1 19 1 20 1 21 1 22 1 23 1 24 1 25 1 26 1 27 1 28 1 29 1 30 1 31 1 32 1
33 1 34 1 35 1 36 1 37 1 38 1 39 1 40 1 41 1 42 1 43 1 44 1 45 1 46 1 47 1 48 1
49 1 50 1 51 1 52 1 53 1 54 1 55 1 56 1 57 1 58 1 59 1 60 1 61 1 62 1 63 1 64 1 end
test u_shape
0000000000000000
0011000011000000
0011000011000000
0011000011000000
0011111111000000
0000000000000000
0000000000001100
0000000000001100
1 20 3 4 end
test empty
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
end
test several
1100000000000011
1100000110000011
0000000110000000
0000000000000000
0111000000011100
0000000000000000
1000000000000001
1111111111111111
1 4 2 4 3 4 4 3 5 3 6 18 end
test full
1111111111111111
1111111111111111
1111111111111111
1111111111111111
1111111111111111
1111111111111111
1111111111111111
1111111111111111
1 128 end

/* files.f */
verilog/ccl_pkg.sv
verilog/ccl_req_if.sv
verilog/ccl_first_pass.sv
verilog/ccl_req_fifo.sv
verilog/ccl_resolver.sv
verilog/ccl_top.sv
dv/ccl_checker.sv
dv/ccl_tb.sv
